//--- store_iq_defs.svh
`ifndef STORE_IQ_DEFS_SVH
`define STORE_IQ_DEFS_SVH

// entries held by each bank, and the width of a slot index into it
`define SIQ_DEPTH 8
`define SIQ_IDX_W 3

// physical register number width, shared by rs1, rs2 and the wakeup tags
`define SIQ_PREG_W 6

// ROB index width, not counting the wrap bit
`define SIQ_ROB_W 5

// store queue index width
`define SIQ_SQ_W 4

// store address offset carried with the address half
`define SIQ_IMM_W 12

// integer wakeup ports broadcast to both banks
`define SIQ_WAKEUP_PORTS 2

`endif

//--- store_iq_pkg.sv
`include "store_iq_defs.svh"

package store_iq_pkg;

    typedef enum logic [1:0] {
        sb = 2'd0,
        sh = 2'd1,
        sw = 2'd2
    } memop_e;

    // access size handed to the store queue
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } store_size_e;

    typedef struct packed {
        logic                  dir;
        logic [`SIQ_ROB_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic                   en;
        rob_idx_t               rob_idx;
        logic [`SIQ_PREG_W-1:0] rs1;
        logic                   rs1_ready;
        logic [`SIQ_PREG_W-1:0] rs2;
        logic                   rs2_ready;
        logic [`SIQ_SQ_W-1:0]   sq_idx;
        memop_e                 memop;
        logic [`SIQ_IMM_W-1:0]  imm;
    } dispatch_t;

    typedef struct packed {
        logic [`SIQ_WAKEUP_PORTS-1:0]                  en;
        logic [`SIQ_WAKEUP_PORTS-1:0][`SIQ_PREG_W-1:0] rd;
    } wakeup_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } redirect_t;

    typedef struct packed {
        logic                   valid;
        rob_idx_t               rob_idx;
        logic [`SIQ_PREG_W-1:0] rs1;
        logic [`SIQ_IMM_W-1:0]  imm;
        logic [`SIQ_SQ_W-1:0]   sq_idx;
        store_size_e            size;
    } addr_issue_t;

    typedef struct packed {
        logic                   valid;
        rob_idx_t               rob_idx;
        logic [`SIQ_PREG_W-1:0] rs2;
        logic [`SIQ_SQ_W-1:0]   sq_idx;
        store_size_e            size;
    } data_issue_t;

    // a is strictly older than b; a differing wrap bit flips the index order
    function automatic logic is_older(rob_idx_t a, rob_idx_t b);
        return (a.dir ^ b.dir) ^ (a.idx < b.idx);
    endfunction

    function automatic store_size_e memop_size(memop_e op);
        case (op)
            sw:      return size_word;
            sh:      return size_half;
            default: return size_byte;
        endcase
    endfunction

endpackage

//--- store_addr_bank.sv
`timescale 1ns/1ns
`include "store_iq_defs.svh"

module store_addr_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_i,
    input  store_iq_pkg::dispatch_t   dis_i,
    input  store_iq_pkg::wakeup_t     wakeup_i,
    input  store_iq_pkg::redirect_t   redirect_i,
    output logic                      full_o,
    output store_iq_pkg::addr_issue_t cand_o
);

    typedef struct packed {
        store_iq_pkg::rob_idx_t    rob_idx;
        logic [`SIQ_PREG_W-1:0]    rs1;
        logic [`SIQ_IMM_W-1:0]     imm;
        logic [`SIQ_SQ_W-1:0]      sq_idx;
        store_iq_pkg::store_size_e size;
    } entry_t;

    entry_t [`SIQ_DEPTH-1:0] ent_q;
    logic   [`SIQ_DEPTH-1:0] valid_q;
    logic   [`SIQ_DEPTH-1:0] rdy_q;

    logic [`SIQ_DEPTH-1:0] ready;
    logic [`SIQ_DEPTH-1:0] wake_hit;
    logic [`SIQ_DEPTH-1:0] keep;
    logic [`SIQ_IDX_W-1:0] free_idx;
    logic [`SIQ_IDX_W-1:0] sel_idx;
    logic                  dis_wake;
    logic                  issue_fire;

    // tag match of every waiting rs1 against both wakeup ports
    always_comb begin
        dis_wake = 1'b0;
        for (int p = 0; p < `SIQ_WAKEUP_PORTS; p++) begin
            if (wakeup_i.en[p] && wakeup_i.rd[p] == dis_i.rs1) begin
                dis_wake = 1'b1;
            end
        end
        for (int i = 0; i < `SIQ_DEPTH; i++) begin
            wake_hit[i] = 1'b0;
            for (int p = 0; p < `SIQ_WAKEUP_PORTS; p++) begin
                if (wakeup_i.en[p] && wakeup_i.rd[p] == ent_q[i].rs1) begin
                    wake_hit[i] = 1'b1;
                end
            end
            keep[i] = store_iq_pkg::is_older(ent_q[i].rob_idx, redirect_i.rob_idx);
        end
    end

    assign ready = valid_q & rdy_q;
    assign full_o = &valid_q;
    assign issue_fire = (|ready) & ~redirect_i.valid;

    // scan from the top so the lowest index wins for both pickers
    always_comb begin
        free_idx = '0;
        sel_idx = '0;
        for (int i = `SIQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = `SIQ_IDX_W'(i);
            end
            if (ready[i]) begin
                sel_idx = `SIQ_IDX_W'(i);
            end
        end
    end

    always_comb begin
        cand_o.valid = issue_fire;
        cand_o.rob_idx = ent_q[sel_idx].rob_idx;
        cand_o.rs1 = ent_q[sel_idx].rs1;
        cand_o.imm = ent_q[sel_idx].imm;
        cand_o.sq_idx = ent_q[sel_idx].sq_idx;
        cand_o.size = ent_q[sel_idx].size;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            rdy_q <= '0;
        end else begin
            for (int i = 0; i < `SIQ_DEPTH; i++) begin
                if (redirect_i.valid) begin
                    // younger stores are squashed, older ones keep waiting
                    valid_q[i] <= valid_q[i] & keep[i];
                end else if (alloc_i && free_idx == `SIQ_IDX_W'(i)) begin
                    valid_q[i] <= 1'b1;
                end else if (issue_fire && sel_idx == `SIQ_IDX_W'(i)) begin
                    valid_q[i] <= 1'b0;
                end
                if (alloc_i && free_idx == `SIQ_IDX_W'(i)) begin
                    rdy_q[i] <= dis_i.rs1_ready | dis_wake;
                end else begin
                    rdy_q[i] <= rdy_q[i] | wake_hit[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            ent_q[free_idx].rob_idx <= dis_i.rob_idx;
            ent_q[free_idx].rs1 <= dis_i.rs1;
            ent_q[free_idx].imm <= dis_i.imm;
            ent_q[free_idx].sq_idx <= dis_i.sq_idx;
            ent_q[free_idx].size <= store_iq_pkg::memop_size(dis_i.memop);
        end
    end

endmodule

//--- store_data_bank.sv
`timescale 1ns/1ns
`include "store_iq_defs.svh"

module store_data_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_i,
    input  store_iq_pkg::dispatch_t   dis_i,
    input  store_iq_pkg::wakeup_t     wakeup_i,
    input  store_iq_pkg::redirect_t   redirect_i,
    output logic                      full_o,
    output store_iq_pkg::data_issue_t cand_o
);

    // the data half needs no immediate, only where the data lands
    typedef struct packed {
        store_iq_pkg::rob_idx_t    rob_idx;
        logic [`SIQ_PREG_W-1:0]    rs2;
        logic [`SIQ_SQ_W-1:0]      sq_idx;
        store_iq_pkg::store_size_e size;
    } entry_t;

    entry_t [`SIQ_DEPTH-1:0] ent_q;
    logic   [`SIQ_DEPTH-1:0] valid_q;
    logic   [`SIQ_DEPTH-1:0] rdy_q;

    logic [`SIQ_DEPTH-1:0] ready;
    logic [`SIQ_DEPTH-1:0] wake_hit;
    logic [`SIQ_DEPTH-1:0] keep;
    logic [`SIQ_IDX_W-1:0] free_idx;
    logic [`SIQ_IDX_W-1:0] sel_idx;
    logic                  dis_wake;
    logic                  issue_fire;

    always_comb begin
        dis_wake = 1'b0;
        for (int p = 0; p < `SIQ_WAKEUP_PORTS; p++) begin
            if (wakeup_i.en[p] && wakeup_i.rd[p] == dis_i.rs2) begin
                dis_wake = 1'b1;
            end
        end
        for (int i = 0; i < `SIQ_DEPTH; i++) begin
            wake_hit[i] = 1'b0;
            for (int p = 0; p < `SIQ_WAKEUP_PORTS; p++) begin
                if (wakeup_i.en[p] && wakeup_i.rd[p] == ent_q[i].rs2) begin
                    wake_hit[i] = 1'b1;
                end
            end
            keep[i] = store_iq_pkg::is_older(ent_q[i].rob_idx, redirect_i.rob_idx);
        end
    end

    assign ready = valid_q & rdy_q;
    assign full_o = &valid_q;
    assign issue_fire = (|ready) & ~redirect_i.valid;

    always_comb begin
        free_idx = '0;
        sel_idx = '0;
        for (int i = `SIQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = `SIQ_IDX_W'(i);
            end
            if (ready[i]) begin
                sel_idx = `SIQ_IDX_W'(i);
            end
        end
    end

    always_comb begin
        cand_o.valid = issue_fire;
        cand_o.rob_idx = ent_q[sel_idx].rob_idx;
        cand_o.rs2 = ent_q[sel_idx].rs2;
        cand_o.sq_idx = ent_q[sel_idx].sq_idx;
        cand_o.size = ent_q[sel_idx].size;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            rdy_q <= '0;
        end else begin
            for (int i = 0; i < `SIQ_DEPTH; i++) begin
                if (redirect_i.valid) begin
                    valid_q[i] <= valid_q[i] & keep[i];
                end else if (alloc_i && free_idx == `SIQ_IDX_W'(i)) begin
                    valid_q[i] <= 1'b1;
                end else if (issue_fire && sel_idx == `SIQ_IDX_W'(i)) begin
                    valid_q[i] <= 1'b0;
                end
                // a wakeup in the dispatch cycle must not be lost
                if (alloc_i && free_idx == `SIQ_IDX_W'(i)) begin
                    rdy_q[i] <= dis_i.rs2_ready | dis_wake;
                end else begin
                    rdy_q[i] <= rdy_q[i] | wake_hit[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            ent_q[free_idx].rob_idx <= dis_i.rob_idx;
            ent_q[free_idx].rs2 <= dis_i.rs2;
            ent_q[free_idx].sq_idx <= dis_i.sq_idx;
            ent_q[free_idx].size <= store_iq_pkg::memop_size(dis_i.memop);
        end
    end

endmodule

//--- store_issue_merge.sv
`timescale 1ns/1ns
`include "store_iq_defs.svh"

module store_issue_merge (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dis_en_i,
    input  logic                      addr_full_i,
    input  logic                      data_full_i,
    input  store_iq_pkg::redirect_t   redirect_i,
    input  store_iq_pkg::addr_issue_t addr_cand_i,
    input  store_iq_pkg::data_issue_t data_cand_i,
    output logic                      alloc_o,
    output logic                      dis_full_o,
    output store_iq_pkg::addr_issue_t addr_issue_o,
    output store_iq_pkg::data_issue_t data_issue_o
);

    store_iq_pkg::addr_issue_t addr_q;
    store_iq_pkg::data_issue_t data_q;
    logic                      addr_vld_q;
    logic                      data_vld_q;
    logic                      addr_stale;
    logic                      data_stale;

    // both halves go in together, so one full bank stalls dispatch
    assign dis_full_o = addr_full_i | data_full_i | redirect_i.valid;
    assign alloc_o = dis_en_i & ~dis_full_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_vld_q <= 1'b0;
            data_vld_q <= 1'b0;
        end else begin
            addr_vld_q <= addr_cand_i.valid;
            data_vld_q <= data_cand_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr_cand_i;
        data_q <= data_cand_i;
    end

    // an issue leaving in the redirect cycle is dropped when it is on the wrong path
    assign addr_stale = redirect_i.valid &
                        ~store_iq_pkg::is_older(addr_q.rob_idx, redirect_i.rob_idx);
    assign data_stale = redirect_i.valid &
                        ~store_iq_pkg::is_older(data_q.rob_idx, redirect_i.rob_idx);

    always_comb begin
        addr_issue_o = addr_q;
        addr_issue_o.valid = addr_vld_q & ~addr_stale;
        data_issue_o = data_q;
        data_issue_o.valid = data_vld_q & ~data_stale;
    end

endmodule

//--- store_issue_queue.sv
`timescale 1ns/1ns
`include "store_iq_defs.svh"

module store_issue_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  store_iq_pkg::dispatch_t   dis_i,
    input  store_iq_pkg::wakeup_t     wakeup_i,
    input  store_iq_pkg::redirect_t   redirect_i,
    output logic                      dis_full_o,
    output store_iq_pkg::addr_issue_t addr_issue_o,
    output store_iq_pkg::data_issue_t data_issue_o
);

    logic                      alloc;
    logic                      addr_full;
    logic                      data_full;
    store_iq_pkg::addr_issue_t addr_cand;
    store_iq_pkg::data_issue_t data_cand;

    store_addr_bank addr_bank_i (
        .clk        (clk),
        .rst        (rst),
        .alloc_i    (alloc),
        .dis_i      (dis_i),
        .wakeup_i   (wakeup_i),
        .redirect_i (redirect_i),
        .full_o     (addr_full),
        .cand_o     (addr_cand)
    );

    store_data_bank data_bank_i (
        .clk        (clk),
        .rst        (rst),
        .alloc_i    (alloc),
        .dis_i      (dis_i),
        .wakeup_i   (wakeup_i),
        .redirect_i (redirect_i),
        .full_o     (data_full),
        .cand_o     (data_cand)
    );

    store_issue_merge merge_i (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_i.en),
        .addr_full_i  (addr_full),
        .data_full_i  (data_full),
        .redirect_i   (redirect_i),
        .addr_cand_i  (addr_cand),
        .data_cand_i  (data_cand),
        .alloc_o      (alloc),
        .dis_full_o   (dis_full_o),
        .addr_issue_o (addr_issue_o),
        .data_issue_o (data_issue_o)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns  = 4,
    parameter int rst_cycles = 16
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // release on a falling edge so that no flop sees reset change at its clock edge
    initial begin
        rst_o = 1'b1;
        repeat (rst_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- store_iq_assertions.sv
`timescale 1ns/1ns
`include "store_iq_defs.svh"

module store_iq_assertions (
    input logic                      clk,
    input logic                      rst,
    input store_iq_pkg::dispatch_t   dis_i,
    input store_iq_pkg::wakeup_t     wakeup_i,
    input store_iq_pkg::redirect_t   redirect_i,
    input logic                      dis_full_i,
    input store_iq_pkg::addr_issue_t addr_issue_i,
    input store_iq_pkg::data_issue_t data_issue_i
);

    localparam int rob_n = 2 ** (`SIQ_ROB_W + 1);
    localparam int wait_limit = 4 * `SIQ_DEPTH;

    int fail_cnt = 0;

    // one expected issue per ROB index and side, cleared when it is seen or squashed
    logic [rob_n-1:0]          pend_a;
    logic [rob_n-1:0]          pend_d;
    logic [rob_n-1:0]          rdy_a;
    logic [rob_n-1:0]          rdy_d;
    store_iq_pkg::addr_issue_t exp_a [rob_n];
    store_iq_pkg::data_issue_t exp_d [rob_n];
    int                        wait_a [rob_n];
    int                        wait_d [rob_n];
    logic [rob_n-1:0]          stale;
    logic                      accept;
    logic                      starved;
    int                        occ_a;
    int                        occ_d;
    int                        rdy_cnt_a;
    int                        rdy_cnt_d;

    function automatic logic older(store_iq_pkg::rob_idx_t a, store_iq_pkg::rob_idx_t b);
        // once the ROB has wrapped between them the larger index is the older one
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx >= b.idx;
    endfunction

    function automatic store_iq_pkg::store_size_e size_of(store_iq_pkg::memop_e op);
        if (op == store_iq_pkg::sw) begin
            return store_iq_pkg::size_word;
        end
        if (op == store_iq_pkg::sh) begin
            return store_iq_pkg::size_half;
        end
        return store_iq_pkg::size_byte;
    endfunction

    function automatic logic wakes(logic [`SIQ_PREG_W-1:0] preg);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `SIQ_WAKEUP_PORTS; p++) begin
            if (wakeup_i.en[p] && wakeup_i.rd[p] == preg) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign accept = dis_i.en & ~dis_full_i;

    always_comb begin
        store_iq_pkg::rob_idx_t ri;
        occ_a = 0;
        occ_d = 0;
        rdy_cnt_a = 0;
        rdy_cnt_d = 0;
        starved = 1'b0;
        for (int r = 0; r < rob_n; r++) begin
            ri = (`SIQ_ROB_W + 1)'(r);
            stale[r] = redirect_i.valid & ~older(ri, redirect_i.rob_idx);
            occ_a += int'(pend_a[r]);
            occ_d += int'(pend_d[r]);
            rdy_cnt_a += int'(pend_a[r] & rdy_a[r]);
            rdy_cnt_d += int'(pend_d[r] & rdy_d[r]);
            if (wait_a[r] > wait_limit || wait_d[r] > wait_limit) begin
                starved = 1'b1;
            end
        end
        // a store on the issue output has already left its bank
        if (addr_issue_i.valid && pend_a[addr_issue_i.rob_idx]) begin
            occ_a--;
            rdy_cnt_a -= int'(rdy_a[addr_issue_i.rob_idx]);
        end
        if (data_issue_i.valid && pend_d[data_issue_i.rob_idx]) begin
            occ_d--;
            rdy_cnt_d -= int'(rdy_d[data_issue_i.rob_idx]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_a <= '0;
            pend_d <= '0;
            rdy_a <= '0;
            rdy_d <= '0;
            for (int r = 0; r < rob_n; r++) begin
                wait_a[r] <= 0;
                wait_d[r] <= 0;
            end
        end else begin
            for (int r = 0; r < rob_n; r++) begin
                wait_a[r] <= (pend_a[r] && rdy_a[r]) ? wait_a[r] + 1 : 0;
                wait_d[r] <= (pend_d[r] && rdy_d[r]) ? wait_d[r] + 1 : 0;
                if (pend_a[r] && wakes(exp_a[r].rs1)) begin
                    rdy_a[r] <= 1'b1;
                end
                if (pend_d[r] && wakes(exp_d[r].rs2)) begin
                    rdy_d[r] <= 1'b1;
                end
                if (stale[r]) begin
                    pend_a[r] <= 1'b0;
                    pend_d[r] <= 1'b0;
                end
            end
            if (addr_issue_i.valid) begin
                pend_a[addr_issue_i.rob_idx] <= 1'b0;
            end
            if (data_issue_i.valid) begin
                pend_d[data_issue_i.rob_idx] <= 1'b0;
            end
            if (accept) begin
                pend_a[dis_i.rob_idx] <= 1'b1;
                pend_d[dis_i.rob_idx] <= 1'b1;
                rdy_a[dis_i.rob_idx] <= dis_i.rs1_ready | wakes(dis_i.rs1);
                rdy_d[dis_i.rob_idx] <= dis_i.rs2_ready | wakes(dis_i.rs2);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exp_a[dis_i.rob_idx] <= '{valid: 1'b1, rob_idx: dis_i.rob_idx, rs1: dis_i.rs1,
                                     imm: dis_i.imm, sq_idx: dis_i.sq_idx,
                                     size: size_of(dis_i.memop)};
            exp_d[dis_i.rob_idx] <= '{valid: 1'b1, rob_idx: dis_i.rob_idx, rs2: dis_i.rs2,
                                     sq_idx: dis_i.sq_idx, size: size_of(dis_i.memop)};
        end
    end

    reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !dis_full_i && !addr_issue_i.valid && !data_issue_i.valid)
        else begin
            fail_cnt++;
            $error("queue outputs are active right after reset");
        end

    redirect_full: assert property (@(posedge clk) disable iff (rst)
        redirect_i.valid |-> dis_full_i)
        else begin
            fail_cnt++;
            $error("CHECK FAILED t=%0t dis_full_o got 0 exp 1", $time);
        end

    addr_expected: assert property (@(posedge clk) disable iff (rst)
        addr_issue_i.valid |-> pend_a[addr_issue_i.rob_idx] && rdy_a[addr_issue_i.rob_idx])
        else begin
            fail_cnt++;
            $error("address issue of ROB %0h that was not waiting with rs1 ready",
                   $sampled(addr_issue_i.rob_idx));
        end

    data_expected: assert property (@(posedge clk) disable iff (rst)
        data_issue_i.valid |-> pend_d[data_issue_i.rob_idx] && rdy_d[data_issue_i.rob_idx])
        else begin
            fail_cnt++;
            $error("data issue of ROB %0h that was not waiting with rs2 ready",
                   $sampled(data_issue_i.rob_idx));
        end

    addr_fields: assert property (@(posedge clk) disable iff (rst)
        addr_issue_i.valid |-> addr_issue_i == exp_a[addr_issue_i.rob_idx])
        else begin
            fail_cnt++;
            $error("CHECK FAILED t=%0t addr_issue_o got %h exp %h", $time,
                   $sampled(addr_issue_i), exp_a[$sampled(addr_issue_i.rob_idx)]);
        end

    data_fields: assert property (@(posedge clk) disable iff (rst)
        data_issue_i.valid |-> data_issue_i == exp_d[data_issue_i.rob_idx])
        else begin
            fail_cnt++;
            $error("CHECK FAILED t=%0t data_issue_o got %h exp %h", $time,
                   $sampled(data_issue_i), exp_d[$sampled(data_issue_i.rob_idx)]);
        end

    no_stale_issue: assert property (@(posedge clk) disable iff (rst)
        redirect_i.valid |->
            (!addr_issue_i.valid || older(addr_issue_i.rob_idx, redirect_i.rob_idx)) &&
            (!data_issue_i.valid || older(data_issue_i.rob_idx, redirect_i.rob_idx)))
        else begin
            fail_cnt++;
            $error("an issue not older than redirect ROB %0h left in the redirect cycle",
                   $sampled(redirect_i.rob_idx));
        end

    addr_progress: assert property (@(posedge clk) disable iff (rst)
        rdy_cnt_a != 0 && !redirect_i.valid |=> addr_issue_i.valid || redirect_i.valid)
        else begin
            fail_cnt++;
            $error("CHECK FAILED t=%0t addr_issue_o.valid got 0 exp 1", $time);
        end

    data_progress: assert property (@(posedge clk) disable iff (rst)
        rdy_cnt_d != 0 && !redirect_i.valid |=> data_issue_i.valid || redirect_i.valid)
        else begin
            fail_cnt++;
            $error("CHECK FAILED t=%0t data_issue_o.valid got 0 exp 1", $time);
        end

    full_set: assert property (@(posedge clk) disable iff (rst)
        occ_a == `SIQ_DEPTH || occ_d == `SIQ_DEPTH |-> dis_full_i)
        else begin
            fail_cnt++;
            $error("CHECK FAILED t=%0t dis_full_o got 0 exp 1", $time);
        end

    full_clear: assert property (@(posedge clk) disable iff (rst)
        !redirect_i.valid && occ_a < `SIQ_DEPTH && occ_d < `SIQ_DEPTH |-> !dis_full_i)
        else begin
            fail_cnt++;
            $error("CHECK FAILED t=%0t dis_full_o got 1 exp 0", $time);
        end

    no_starve: assert property (@(posedge clk) disable iff (rst) !starved)
        else begin
            fail_cnt++;
            $error("a ready store waited more than %0d cycles without issuing", wait_limit);
        end

endmodule

//--- store_iq_tb.sv
`timescale 1ns/1ns
`include "store_iq_defs.svh"

module store_iq_tb;

    localparam int test_count = 6;
    localparam int test_len = 300;
    localparam int watchdog_cycles = test_count * test_len + 100;
    localparam int drain_cycles = 4 * `SIQ_DEPTH + 8;

    logic                      clk;
    logic                      rst;
    store_iq_pkg::dispatch_t   dis;
    store_iq_pkg::wakeup_t     wakeup;
    store_iq_pkg::redirect_t   redirect;
    logic                      dis_full;
    store_iq_pkg::addr_issue_t addr_issue;
    store_iq_pkg::data_issue_t data_issue;

    integer                seed;
    int                    tb_errors;
    int                    tests_run;
    int                    fail_mark;
    logic [`SIQ_ROB_W:0]   next_rob;

    tb_clock_gen #(.period_ns(4), .rst_cycles(16)) clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    store_issue_queue dut_i (
        .clk          (clk),
        .rst          (rst),
        .dis_i        (dis),
        .wakeup_i     (wakeup),
        .redirect_i   (redirect),
        .dis_full_o   (dis_full),
        .addr_issue_o (addr_issue),
        .data_issue_o (data_issue)
    );

    bind store_issue_queue store_iq_assertions chk_i (
        .clk          (clk),
        .rst          (rst),
        .dis_i        (dis_i),
        .wakeup_i     (wakeup_i),
        .redirect_i   (redirect_i),
        .dis_full_i   (dis_full_o),
        .addr_issue_i (addr_issue_o),
        .data_issue_i (data_issue_o)
    );

    function automatic int total_failures();
        return tb_errors + dut_i.chk_i.fail_cnt;
    endfunction

    function automatic logic [`SIQ_PREG_W-1:0] random_reg(input logic [`SIQ_PREG_W-1:0] mask);
        return `SIQ_PREG_W'($random(seed)) & mask;
    endfunction

    task automatic settle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // holds the store until the queue takes it, like a stalled rename stage
    task automatic dispatch_store(input logic rs1_rdy, input logic [`SIQ_PREG_W-1:0] rs1,
                                  input logic rs2_rdy, input logic [`SIQ_PREG_W-1:0] rs2);
        int   tries;
        logic taken;
        tries = 0;
        taken = 1'b0;
        dis.en = 1'b1;
        dis.rob_idx = next_rob;
        dis.rs1 = rs1;
        dis.rs1_ready = rs1_rdy;
        dis.rs2 = rs2;
        dis.rs2_ready = rs2_rdy;
        dis.sq_idx = `SIQ_SQ_W'($random(seed));
        dis.memop = store_iq_pkg::memop_e'($unsigned($random(seed)) % 3);
        dis.imm = `SIQ_IMM_W'($random(seed));
        while (!taken && tries < 50) begin
            #1;
            taken = !dis_full;
            @(negedge clk);
            tries++;
        end
        dis.en = 1'b0;
        if (taken) begin
            next_rob = next_rob + 1'b1;
        end else begin
            tb_errors++;
            $display("store with ROB %0h was never accepted by the queue", next_rob);
        end
    endtask

    task automatic wake_regs(input logic [`SIQ_PREG_W-1:0] a, input logic a_en,
                             input logic [`SIQ_PREG_W-1:0] b, input logic b_en);
        wakeup.en = {b_en, a_en};
        wakeup.rd[0] = a;
        wakeup.rd[1] = b;
        @(negedge clk);
        wakeup.en = '0;
    endtask

    task automatic send_redirect(input logic [`SIQ_ROB_W:0] rob);
        redirect.valid = 1'b1;
        redirect.rob_idx = rob;
        @(negedge clk);
        redirect.valid = 1'b0;
        next_rob = rob;
    endtask

    // every register gets woken so that nothing is left waiting
    task automatic drain();
        for (int r = 0; r < 2 ** `SIQ_PREG_W; r += 2) begin
            wake_regs(`SIQ_PREG_W'(r), 1'b1, `SIQ_PREG_W'(r + 1), 1'b1);
        end
        settle(drain_cycles);
    endtask

    task automatic finish_test(input string name);
        int now_fail;
        now_fail = total_failures();
        tests_run++;
        if (now_fail == fail_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d failures", name, now_fail - fail_mark);
        end
        fail_mark = now_fail;
    endtask

    task automatic random_mix();
        int dispatched;
        int pick;
        dispatched = 0;
        for (int i = 0; i < 60; i++) begin
            pick = $unsigned($random(seed)) % 8;
            if (pick < 3 && dispatched < 24 && !dis_full) begin
                dispatch_store(1'($random(seed)), random_reg(6'h0f),
                               1'($random(seed)), random_reg(6'h0f));
                dispatched++;
            end else if (pick == 7) begin
                send_redirect(next_rob - (`SIQ_ROB_W + 1)'(1 + $unsigned($random(seed)) % 4));
            end else begin
                wake_regs(random_reg(6'h0f), 1'($random(seed)),
                          random_reg(6'h0f), 1'($random(seed)));
            end
        end
    endtask

    initial begin
        logic [`SIQ_ROB_W:0] base;
        seed = 32'hda18;
        tb_errors = 0;
        tests_run = 0;
        fail_mark = 0;
        dis = '0;
        wakeup = '0;
        redirect = '0;
        next_rob = (`SIQ_ROB_W + 1)'($random(seed));

        while (rst) @(negedge clk);
        settle(4);
        finish_test("reset state");

        repeat (6) dispatch_store(1'b1, random_reg(6'h3f), 1'b1, random_reg(6'h3f));
        settle(12);
        finish_test("ready dispatch");

        repeat (6) dispatch_store(1'b0, random_reg(6'h3f), 1'b0, random_reg(6'h3f));
        repeat (24) wake_regs(random_reg(6'h3f), 1'($random(seed)),
                              random_reg(6'h3f), 1'($random(seed)));
        drain();
        finish_test("wakeup");

        for (int i = 0; i < `SIQ_DEPTH; i++) begin
            dispatch_store(1'b0, `SIQ_PREG_W'(40 + i), 1'b0, `SIQ_PREG_W'(48 + i));
        end
        // a ninth store waits on the full flag until one slot per bank issues
        fork
            dispatch_store(1'b0, 6'd7, 1'b0, 6'd7);
            begin
                settle(3);
                wake_regs(6'd40, 1'b1, 6'd48, 1'b1);
            end
        join
        drain();
        finish_test("full queue");

        base = next_rob;
        repeat (4) dispatch_store(1'b0, random_reg(6'h3f), 1'b0, random_reg(6'h3f));
        repeat (2) dispatch_store(1'b1, random_reg(6'h3f), 1'b1, random_reg(6'h3f));
        // the first ready store sits on the issue outputs during this redirect
        send_redirect(base + (`SIQ_ROB_W + 1)'(2));
        settle(2);
        repeat (2) dispatch_store(1'b0, random_reg(6'h3f), 1'b0, random_reg(6'h3f));
        drain();
        finish_test("redirect");

        random_mix();
        drain();
        finish_test("random mix");

        $display("tests run: %0d, failures: %0d", tests_run, total_failures());
        if (total_failures() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
store_iq_pkg.sv
store_addr_bank.sv
store_data_bank.sv
store_issue_merge.sv
store_issue_queue.sv
tb_clock_gen.sv
store_iq_assertions.sv
store_iq_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only when the testbench prints its pass line
verilator --binary --timing --assert -Wno-fatal --top-module store_iq_tb \
    -f filelist.f -o store_iq_sim || exit 1
out=$(./obj_dir/store_iq_sim +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Regression passed" && exit 0 || exit 1
